// ==== hdl/mem_bus_pkg.sv ====
`default_nettype none

// memory bus encodings shared by the fetch front end and the memory model
package mem_bus_pkg;

    localparam int xlen          = 32;  // address width
    localparam int mem_tag_width = 4;   // tag zero means no transaction

    // command toward memory
    typedef enum logic [1:0] {
        bus_none = 2'h0,    // idle
        bus_load = 2'h1     // read one 8 byte line
    } bus_command_t;

endpackage

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
`default_nettype none

// instruction cache geometry and the line type
package icache_pkg;

    localparam int cache_lines       = 32;
    localparam int line_index_bits   = $clog2(cache_lines);
    localparam int line_offset_bits  = 3;                      // 8 byte lines
    localparam int line_bytes        = 1 << line_offset_bits;
    localparam int line_tag_bits     = 8;                      // address bits 15:8
    localparam int line_bits         = 64;
    localparam int slot_bits         = 32;                     // one instruction

    localparam int prefetch_depth    = 4;
    localparam int prefetch_ptr_bits = $clog2(prefetch_depth);

    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // a line is either the raw memory word or two instruction slots,
    // slot[1] is the upper word and slot[0] the lower one
    typedef union packed {
        logic [line_bits-1:0]      raw;
        logic [1:0][slot_bits-1:0] slot;
    } cache_line_u;

endpackage

`default_nettype wire

// ==== hdl/icache_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// prefetch queue <-> miss unit, requests going out and returns coming back
interface prefetch_req_if import mem_bus_pkg::*, icache_pkg::*; ();
    logic                     req_valid;
    logic [xlen-1:0]          req_addr;     // line aligned
    logic                     grant;        // bus free of demand loads
    logic [mem_tag_width-1:0] resp_tag;     // mem_response this cycle
    logic [mem_tag_width-1:0] data_tag;     // returning tag broadcast
    cache_line_u              data;         // returning line broadcast
    logic                     fill_valid;   // oldest sent entry came back
    logic [xlen-1:0]          fill_addr;
    cache_line_u              fill_line;

    modport queue (
        output req_valid, req_addr, fill_valid, fill_addr, fill_line,
        input  grant, resp_tag, data_tag, data
    );
    modport miss (
        input  req_valid, req_addr, fill_valid, fill_addr, fill_line,
        output grant, resp_tag, data_tag, data
    );
endinterface

// single write port into the line storage
interface line_fill_if import icache_pkg::*; ();
    logic                       we;
    logic [line_index_bits-1:0] index;
    logic [line_tag_bits-1:0]   tag;
    cache_line_u                data;

    modport writer (output we, index, tag, data);
    modport array  (input  we, index, tag, data);
endinterface

`default_nettype wire

// ==== hdl/icache_array.sv ====
`timescale 1ns/10ps
`default_nettype none

// direct mapped line storage, combinational lookup and one fill per cycle
module icache_array import mem_bus_pkg::*, icache_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic [xlen-1:0] fetch_addr,
    line_fill_if.array      fill,
    output cache_line_u     line,
    output logic            line_hit
);

    cache_line_u              line_data [cache_lines];
    logic [line_tag_bits-1:0] line_tag  [cache_lines];
    logic [cache_lines-1:0]   line_valid;

    logic [line_index_bits-1:0] lookup_index;
    logic [line_tag_bits-1:0]   lookup_tag;

    // address split: tag 15:8, index 7:3, byte offset 2:0
    assign lookup_index = fetch_addr[line_offset_bits +: line_index_bits];
    assign lookup_tag   = fetch_addr[line_offset_bits + line_index_bits +: line_tag_bits];

    assign line     = line_data[lookup_index];
    assign line_hit = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill.we) begin
            line_valid[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill.we) begin
            line_data[fill.index] <= fill.data;
            line_tag[fill.index]  <= fill.tag;  // overwrites whatever mapped here
        end
    end

endmodule

`default_nettype wire

// ==== hdl/icache_miss_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

// one outstanding demand miss, bus arbitration and the fill write port
module icache_miss_unit import mem_bus_pkg::*, icache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     redirect_valid,
    input  logic [xlen-1:0]          fetch_addr,
    input  logic                     line_hit,
    prefetch_req_if.miss             prefetch,
    line_fill_if.writer              fill,
    output bus_command_t             mem_command,
    output logic [xlen-1:0]          mem_addr,
    input  logic [mem_tag_width-1:0] mem_response,
    input  logic [line_bits-1:0]     mem_data,
    input  logic [mem_tag_width-1:0] mem_data_tag
);

    logic [line_tag_bits-1:0]   cur_tag, last_tag;
    logic [line_index_bits-1:0] cur_index, last_index;
    logic [mem_tag_width-1:0]   demand_tag;     // tag of the accepted demand load
    logic recheck;                              // forces a lookup after reset or redirect
    logic miss_outstanding, miss_next;
    logic pf_hold;                              // refused prefetch keeps the bus
    logic changed_addr, demand_load, demand_accept, demand_fill, prefetch_refused;

    assign cur_index = fetch_addr[line_offset_bits +: line_index_bits];
    assign cur_tag   = fetch_addr[line_offset_bits + line_index_bits +: line_tag_bits];

    assign changed_addr     = recheck || (cur_tag != last_tag) || (cur_index != last_index);
    assign demand_load      = miss_outstanding && !changed_addr && !pf_hold;
    assign demand_accept    = demand_load && (mem_response != '0);
    // data for a line the counter already left is dropped
    assign demand_fill      = !changed_addr && (demand_tag != '0)
                              && (demand_tag == mem_data_tag);
    assign prefetch_refused = prefetch.req_valid && prefetch.grant && (mem_response == '0);

    always_comb begin
        if (changed_addr) begin
            miss_next = !line_hit;
        end else if (miss_outstanding) begin
            miss_next = !demand_accept;         // keep offering until accepted
        end else begin
            // line lost to a conflicting fill with nothing pending
            miss_next = !line_hit && (demand_tag == '0);
        end
    end

    // demand load wins the bus, prefetch gets the idle cycles
    assign prefetch.grant    = !demand_load;
    assign prefetch.resp_tag = mem_response;
    assign prefetch.data_tag = mem_data_tag;
    assign prefetch.data     = mem_data;

    assign mem_command = (demand_load || prefetch.req_valid) ? bus_load : bus_none;
    assign mem_addr    = demand_load
                         ? {fetch_addr[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}}
                         : prefetch.req_addr;

    always_comb begin
        fill.we = demand_fill || prefetch.fill_valid;
        if (demand_fill) begin
            fill.index    = cur_index;
            fill.tag      = cur_tag;
            fill.data.raw = mem_data;
        end else begin
            fill.index = prefetch.fill_addr[line_offset_bits +: line_index_bits];
            fill.tag   = prefetch.fill_addr[line_offset_bits + line_index_bits +: line_tag_bits];
            fill.data  = prefetch.fill_line;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            recheck          <= 1'b1;
            miss_outstanding <= 1'b0;
            demand_tag       <= '0;
            pf_hold          <= 1'b0;
        end else begin
            pf_hold <= prefetch_refused;
            if (redirect_valid) begin
                recheck          <= 1'b1;   // squash drops the demand miss
                miss_outstanding <= 1'b0;
                demand_tag       <= '0;
            end else begin
                recheck          <= 1'b0;
                miss_outstanding <= miss_next;
                if (demand_accept) begin
                    demand_tag <= mem_response;
                end else if (changed_addr || demand_fill) begin
                    demand_tag <= '0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        last_tag   <= cur_tag;
        last_index <= cur_index;
    end

endmodule

`default_nettype wire

// ==== hdl/icache_prefetch_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

// next line prefetch, a small in order miss status queue
module icache_prefetch_queue import mem_bus_pkg::*, icache_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic [xlen-1:0] fetch_addr,
    input  logic            line_hit,
    prefetch_req_if.queue   req
);

    logic [xlen-1:0]          entry_addr [prefetch_depth];
    logic [mem_tag_width-1:0] entry_tag  [prefetch_depth];
    logic [prefetch_depth-1:0] entry_valid;
    logic [prefetch_depth-1:0] entry_sent;

    logic [prefetch_ptr_bits-1:0] alloc_ptr, send_ptr, retire_ptr;

    logic [xlen-1:0] next_line;
    logic [xlen-1:0] last_alloc;    // most recent line put in the queue
    logic            last_alloc_valid;
    logic            pending_dup;
    logic            do_alloc, do_send, do_retire;

    assign next_line = {fetch_addr[xlen-1:line_offset_bits], {line_offset_bits{1'b0}}}
                       + line_bytes;

    always_comb begin
        pending_dup = last_alloc_valid && (last_alloc == next_line);
        for (int i = 0; i < prefetch_depth; i++) begin
            if (entry_valid[i] && (entry_addr[i] == next_line)) begin
                pending_dup = 1'b1;
            end
        end
    end

    assign do_alloc = !line_hit && !entry_valid[alloc_ptr] && !pending_dup;

    // only one prefetch in flight, so the oldest sent entry is the one returning
    assign req.req_valid = entry_valid[send_ptr] && !entry_sent[send_ptr]
                           && (send_ptr == retire_ptr);
    assign req.req_addr  = entry_addr[send_ptr];

    assign do_send   = req.req_valid && req.grant && (req.resp_tag != '0);
    assign do_retire = entry_valid[retire_ptr] && entry_sent[retire_ptr]
                       && (req.data_tag != '0) && (req.data_tag == entry_tag[retire_ptr]);

    assign req.fill_valid = do_retire;
    assign req.fill_addr  = entry_addr[retire_ptr];
    assign req.fill_line  = req.data;

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid      <= '0;
            entry_sent       <= '0;
            alloc_ptr        <= '0;
            send_ptr         <= '0;
            retire_ptr       <= '0;
            last_alloc_valid <= 1'b0;
        end else begin
            if (do_alloc) begin
                entry_valid[alloc_ptr] <= 1'b1;
                entry_sent[alloc_ptr]  <= 1'b0;
                alloc_ptr              <= alloc_ptr + 1'b1;
                last_alloc_valid       <= 1'b1;
            end
            if (do_send) begin
                entry_sent[send_ptr] <= 1'b1;   // zero response leaves it unsent
                send_ptr             <= send_ptr + 1'b1;
            end
            if (do_retire) begin
                entry_valid[retire_ptr] <= 1'b0;
                entry_sent[retire_ptr]  <= 1'b0;
                retire_ptr              <= retire_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_alloc) begin
            entry_addr[alloc_ptr] <= next_line;
            last_alloc            <= next_line;
        end
        if (do_send) begin
            entry_tag[send_ptr] <= req.resp_tag;  // tag named in the accept cycle
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

// program counter and instruction select
module fetch_stage import mem_bus_pkg::*, icache_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 redirect_valid,
    input  logic [xlen-1:0]      redirect_pc,
    input  cache_line_u          line,
    input  logic                 line_hit,
    output logic [xlen-1:0]      fetch_addr,
    output logic [slot_bits-1:0] inst,
    output logic [xlen-1:0]      inst_pc,
    output logic                 inst_valid
);

    logic [xlen-1:0] pc;
    logic            advance;

    // move on only when the word is really there
    assign advance = line_hit && !stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (redirect_valid) begin
            pc <= redirect_pc;          // wins over stall
        end else if (advance) begin
            pc <= pc + 4;
        end
    end

    assign fetch_addr = pc;

    // bit 2 picks the upper or lower word of the line
    assign inst       = line.slot[pc[line_offset_bits-1]];
    assign inst_pc    = pc;
    assign inst_valid = line_hit;

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// instruction fetch front end
module fetch_top import mem_bus_pkg::*, icache_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     stall,
    input  logic                     redirect_valid,
    input  logic [xlen-1:0]          redirect_pc,
    output logic [slot_bits-1:0]     inst,
    output logic [xlen-1:0]          inst_pc,
    output logic                     inst_valid,
    output bus_command_t             mem_command,
    output logic [xlen-1:0]          mem_addr,
    input  logic [mem_tag_width-1:0] mem_response,
    input  logic [line_bits-1:0]     mem_data,
    input  logic [mem_tag_width-1:0] mem_data_tag
);

    logic [xlen-1:0] fetch_addr;
    cache_line_u     line;
    logic            line_hit;

    prefetch_req_if prefetch_i ();
    line_fill_if    fill_i ();

    fetch_stage fetch_i (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .line           (line),
        .line_hit       (line_hit),
        .fetch_addr     (fetch_addr),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_valid     (inst_valid)
    );

    icache_array array_i (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fill       (fill_i.array),
        .line       (line),
        .line_hit   (line_hit)
    );

    icache_miss_unit miss_i (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .fetch_addr     (fetch_addr),
        .line_hit       (line_hit),
        .prefetch       (prefetch_i.miss),
        .fill           (fill_i.writer),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .mem_response   (mem_response),
        .mem_data       (mem_data),
        .mem_data_tag   (mem_data_tag)
    );

    icache_prefetch_queue prefetch_queue_i (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .line_hit   (line_hit),
        .req        (prefetch_i.queue)
    );

endmodule

`default_nettype wire

// ==== verification/tagged_memory_model.sv ====
`timescale 1ns/10ps
`default_nettype none

// memory with tagged responses, variable latency and random refusals
module tagged_memory_model import mem_bus_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  bus_command_t             mem_command,
    input  logic [xlen-1:0]          mem_addr,
    output logic [mem_tag_width-1:0] mem_response,
    output logic [63:0]              mem_data,
    output logic [mem_tag_width-1:0] mem_data_tag
);

    integer seed = 32'h3495_a2ec;

    logic [mem_tag_width-1:0] pend_tag [$];
    logic [xlen-1:0]          pend_addr [$];
    int                       pend_due [$];
    int                       now = 0;
    logic                     offer_taken = 1'b0;    // load accepted in this cycle
    logic [xlen-1:0]          offer_addr = '0;

    // word at A is A xor 5a5a_0000, upper half holds A+4
    function automatic logic [63:0] line_of(input logic [xlen-1:0] addr);
        logic [xlen-1:0] base;
        base = {addr[xlen-1:3], 3'b000};
        return {(base + 32'd4) ^ 32'h5a5a_0000, base ^ 32'h5a5a_0000};
    endfunction

    function automatic logic tag_in_flight(input logic [mem_tag_width-1:0] t);
        logic busy;
        busy = (t == mem_data_tag);
        foreach (pend_tag[i]) begin
            if (pend_tag[i] == t) busy = 1'b1;
        end
        return busy;
    endfunction

    initial begin
        mem_response = '0;
        mem_data     = '0;
        mem_data_tag = '0;
    end

    always begin
        int pick;
        int tag;
        @(posedge clock);
        if (reset) begin
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
        end else if (offer_taken) begin
            pend_tag.push_back(mem_response);
            pend_addr.push_back(offer_addr);
            pend_due.push_back(now + 2 + int'($unsigned($random(seed)) % 5));
        end
        #2;
        now++;

        // at most one return per cycle, oldest due first
        mem_data_tag = '0;
        pick = -1;
        for (int i = 0; i < pend_due.size(); i++) begin
            if (pick < 0 && pend_due[i] <= now) pick = i;
        end
        if (pick >= 0) begin
            mem_data_tag = pend_tag[pick];
            mem_data     = line_of(pend_addr[pick]);
            pend_tag.delete(pick);
            pend_addr.delete(pick);
            pend_due.delete(pick);
        end

        offer_taken  = 1'b0;
        mem_response = '0;
        if (!reset && mem_command == bus_load && ($random(seed) & 3) != 0) begin
            tag = 1 + int'($unsigned($random(seed)) % 15);
            while (tag_in_flight(4'(tag))) tag = tag % 15 + 1;
            mem_response = 4'(tag);
            offer_taken  = 1'b1;
            offer_addr   = mem_addr;
        end
    end

endmodule

`default_nettype wire

// ==== verification/fetch_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

// bus protocol and reset state checks, bound into fetch_top
module fetch_properties import mem_bus_pkg::*; (
    input logic                     clock,
    input logic                     reset,
    input logic                     redirect_valid,
    input logic                     inst_valid,
    input bus_command_t             mem_command,
    input logic [xlen-1:0]          mem_addr,
    input logic [mem_tag_width-1:0] mem_response
);

    int fail_count = 0;     // read by the testbench at the end

    reset_quiet: assert property (@(posedge clock)
        reset |=> (mem_command == bus_none && !inst_valid))
    else begin
        $error("bus active or instruction valid right after reset");
        fail_count++;
    end

    // refused load keeps its address, unless a squash or a fill moves on
    load_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command == bus_load && mem_response == '0 && !redirect_valid && !inst_valid)
        |=> (mem_command == bus_load && $stable(mem_addr)))
    else begin
        $error("unaccepted load dropped or changed its address");
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== verification/fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_tb import mem_bus_pkg::*; ();

    localparam logic [31:0] inst_key          = 32'h5a5a_0000;
    localparam logic [31:0] expected_reset_pc = 32'h0000_0000;
    localparam int          test_cycles       = 800;    // rough sum over all tests
    localparam int          cycle_limit       = 10 * test_cycles;

    logic clock, reset, stall, redirect_valid;
    logic [31:0] redirect_pc, inst, inst_pc, mem_addr;
    logic inst_valid;
    bus_command_t mem_command;
    logic [mem_tag_width-1:0] mem_response, mem_data_tag;
    logic [63:0] mem_data;

    int errors = 0;
    int start_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    logic [31:0] exp_pc, held_pc, held_inst, pf_target;
    logic held = 1'b0;
    logic second_pass = 1'b0;   // no bus traffic allowed
    logic pf_armed = 1'b0;
    logic pf_seen = 1'b0;

    fetch_top dut_i (.*);
    tagged_memory_model mem_i (.*);

    bind fetch_top fetch_properties props_i (
        .clock(clock), .reset(reset), .redirect_valid(redirect_valid),
        .inst_valid(inst_valid), .mem_command(mem_command),
        .mem_addr(mem_addr), .mem_response(mem_response)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, fetch never reached its target", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // checks sampled mid cycle, inputs and outputs are settled
    always @(negedge clock) begin
        if (reset) begin
            exp_pc    = expected_reset_pc;
            held      = 1'b0;
        end else begin
            if (inst_valid) begin
                assert (inst == (inst_pc ^ inst_key)) else begin
                    $display("Mismatch at %0t: inst expected %h got %h",
                             $time, inst_pc ^ inst_key, inst);
                    errors++;
                end
                assert (inst_pc == exp_pc) else begin
                    $display("Mismatch at %0t: inst_pc expected %h got %h",
                             $time, exp_pc, inst_pc);
                    errors++;
                end
                if (held) assert (inst_pc == held_pc && inst == held_inst) else begin
                    $display("Mismatch at %0t: inst_pc/inst under stall expected %h/%h got %h/%h",
                             $time, held_pc, held_inst, inst_pc, inst);
                    errors++;
                end
            end
            if (second_pass) assert (mem_command != bus_load) else begin
                $display("load of %h at %0t while looping over cached code", mem_addr, $time);
                errors++;
            end
            // counter inside the target line, its prefetch must be out already
            if (pf_armed && inst_pc[31:3] == pf_target[31:3]) assert (pf_seen)
            else begin
                $display("fetch reached line %h at %0t before its prefetch", pf_target, $time);
                errors++;
            end
            if (pf_armed && mem_command == bus_load && mem_addr == pf_target) pf_seen = 1'b1;
            held      = inst_valid && stall && !redirect_valid;
            held_pc   = inst_pc;
            held_inst = inst;
            if (redirect_valid) exp_pc = redirect_pc;
            else if (inst_valid && !stall) exp_pc = inst_pc + 32'd4;
        end
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic run_to(input logic [31:0] target);
        while (!(inst_valid && inst_pc == target)) step();
    endtask

    task automatic redirect_to(input logic [31:0] addr);
        redirect_valid = 1'b1;
        redirect_pc    = addr;
        stall          = 1'b0;
        step();
        redirect_valid = 1'b0;
    endtask

    // hold the counter until the bus has been quiet for a while
    task automatic settle();
        int idle;
        idle  = 0;
        stall = 1'b1;
        while (idle < 10) begin
            step();
            idle = (mem_command == bus_none) ? idle + 1 : 0;
        end
    endtask

    task automatic begin_test();
        start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != start_errors) tests_failed++;
        $display("%-14s %s, %0d errors", name,
                 (errors == start_errors) ? "passed" : "failed", errors - start_errors);
    endtask

    initial begin
        int n;
        reset          = 1'b1;
        stall          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;

        begin_test();
        run_to(32'h0000_003c);
        settle();
        end_test("straight_run");

        begin_test();
        redirect_to(32'h0000_0040);
        n = 0;
        while (!(inst_valid && inst_pc == 32'h0000_007c)) begin
            stall = (n % 3 == 1);   // stall pulses mid stream
            step();
            n++;
        end
        settle();
        end_test("stall");

        begin_test();
        redirect_to(32'h0000_2000);
        run_to(32'h0000_2004);
        redirect_to(32'h0000_2800);
        step();
        step();
        redirect_to(32'h0000_3000);   // squash the pending miss
        run_to(32'h0000_300c);
        settle();
        end_test("redirect");

        begin_test();
        redirect_to(32'h0000_0100);
        run_to(32'h0000_017c);
        settle();
        second_pass = 1'b1;
        redirect_to(32'h0000_0100);
        run_to(32'h0000_017c);
        stall       = 1'b1;
        second_pass = 1'b0;
        settle();
        end_test("loop_hits");

        begin_test();
        pf_target = 32'h0000_4008;
        pf_seen   = 1'b0;
        pf_armed  = 1'b1;
        redirect_to(32'h0000_4000);
        run_to(32'h0000_400c);
        stall    = 1'b1;
        pf_armed = 1'b0;
        settle();
        end_test("prefetch");

        errors += dut_i.props_i.fail_count;
        $display("%0d tests, %0d failed, %0d errors, %0d from properties",
                 tests_run, tests_failed, errors, dut_i.props_i.fail_count);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/mem_bus_pkg.sv
hdl/icache_pkg.sv
hdl/icache_if.sv
hdl/icache_array.sv
hdl/icache_miss_unit.sv
hdl/icache_prefetch_queue.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
verification/tagged_memory_model.sv
verification/fetch_properties.sv
verification/fetch_tb.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := fetch_tb
FILELIST  := all.f
BUILD     := obj_dir
RUN_ARGS  := +verilator+error+limit+1000

BIN       := $(BUILD)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# output goes to the terminal, the status comes from the search
run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf $(BUILD)
